//--- rtl/dma_stats_config.svh
`ifndef DMA_STATS_CONFIG_SVH
`define DMA_STATS_CONFIG_SVH

// width of every event counter. the counters wrap silently at this width.
`define DMA_CNT_BITS 32

// width of each outstanding-request gauge.
// the gauges saturate instead of wrapping.
`define DMA_GAUGE_BITS 8

// number of register-slice stages on the statistics record.
// one stage means the record leaves straight from the counters.
// each extra stage adds one cycle of latency toward the readout.
`define DMA_STATS_DELAY 2

`endif

//--- rtl/dma_stats_pkg.sv
`include "dma_stats_config.svh"

package dma_stats_pkg;

  localparam int DMA_NUM_EVENTS = 6; // one bit per event kind in the captured vector.

  // position of each event in the captured strobe vector.
  // the counter array in the stats stage uses the same order.
  typedef enum logic [2:0] {
    EV_RD_REQ  = 3'd0, // host read request issued.
    EV_WR_REQ  = 3'd1, // host write request issued.
    EV_RD_DONE = 3'd2, // read completion returned.
    EV_WR_DONE = 3'd3, // write completion returned.
    EV_AXIS_RD = 3'd4, // one streaming beat toward the card.
    EV_AXIS_WR = 3'd5  // one streaming beat toward the host.
  } dma_event_e;

  // the full statistics record as it leaves the counting stage.
  typedef struct packed {
    logic [`DMA_CNT_BITS-1:0]   rd_req;
    logic [`DMA_CNT_BITS-1:0]   wr_req;
    logic [`DMA_CNT_BITS-1:0]   rd_done;
    logic [`DMA_CNT_BITS-1:0]   wr_done;
    logic [`DMA_CNT_BITS-1:0]   axis_rd;
    logic [`DMA_CNT_BITS-1:0]   axis_wr;
    logic [`DMA_GAUGE_BITS-1:0] rd_outstanding; // read requests still waiting.
    logic [`DMA_GAUGE_BITS-1:0] wr_outstanding; // write requests still waiting.
    logic                       rd_err;         // sticky, set on overflow or underflow.
    logic                       wr_err;
  } dma_stat_t;

endpackage

//--- rtl/dma_reg_pkg.sv
`include "dma_stats_config.svh"

package dma_reg_pkg;

  localparam int DMA_REG_ADDR_BITS = 4; // sixteen addresses, only eight are mapped.

  // host visible register map.
  typedef enum logic [DMA_REG_ADDR_BITS-1:0] {
    REG_RD_REQ  = 4'd0,
    REG_WR_REQ  = 4'd1,
    REG_RD_DONE = 4'd2,
    REG_WR_DONE = 4'd3,
    REG_AXIS_RD = 4'd4,
    REG_AXIS_WR = 4'd5,
    REG_GAUGES  = 4'd6, // both gauges packed into the low half.
    REG_ERRORS  = 4'd7  // the two sticky error flags.
  } dma_reg_addr_e;

  // field placement inside the gauge register.
  localparam int REG_GAUGE_RD_LSB = 0;
  localparam int REG_GAUGE_WR_LSB = `DMA_GAUGE_BITS;

  // bit placement inside the error register.
  localparam int REG_ERR_RD_BIT = 0;
  localparam int REG_ERR_WR_BIT = 1;

endpackage

//--- rtl/dma_event_capture.sv
`timescale 1ns/1ps

module dma_event_capture (
  input  logic                                     aclk,
  input  logic                                     aresetn,

  input  logic                                     dma_rd_req,
  input  logic                                     dma_rd_done,
  input  logic                                     dma_wr_req,
  input  logic                                     dma_wr_done,
  input  logic                                     axis_rd,
  input  logic                                     axis_wr,

  input  logic                                     rd_gauge_zero, // read gauge empty after this edge.
  input  logic                                     wr_gauge_zero, // write gauge empty after this edge.

  output logic [dma_stats_pkg::DMA_NUM_EVENTS-1:0] ev,
  output logic                                     rd_underflow,
  output logic                                     wr_underflow
);

  import dma_stats_pkg::*;

  // the gauge_zero inputs already include every event captured earlier, so a
  // completion seen here is judged against the gauge as it will stand once the
  // pending updates have landed.
  // a completion that arrives on the same edge as its own request is still
  // counted as an underflow, because the request has not been counted yet.

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ev           <= '0;
      rd_underflow <= 1'b0;
      wr_underflow <= 1'b0;
    end else begin
      ev[EV_RD_REQ]  <= dma_rd_req; // requests are always accepted.
      ev[EV_WR_REQ]  <= dma_wr_req;
      ev[EV_AXIS_RD] <= axis_rd;    // streaming beats carry no ordering rule.
      ev[EV_AXIS_WR] <= axis_wr;

      // completions pass only when something is outstanding.
      ev[EV_RD_DONE] <= dma_rd_done & ~rd_gauge_zero;
      ev[EV_WR_DONE] <= dma_wr_done & ~wr_gauge_zero;

      // an orphan completion becomes an error pulse instead.
      rd_underflow   <= dma_rd_done & rd_gauge_zero;
      wr_underflow   <= dma_wr_done & wr_gauge_zero;
    end
  end

endmodule

//--- rtl/dma_stats.sv
`timescale 1ns/1ps

`include "dma_stats_config.svh"

module dma_stats (
  input  logic                                     aclk,
  input  logic                                     aresetn,

  input  logic                                     clear,        // zeroes every statistic.
  input  logic [dma_stats_pkg::DMA_NUM_EVENTS-1:0] ev,           // captured event strobes.
  input  logic                                     rd_underflow,
  input  logic                                     wr_underflow,

  output logic                                     rd_gauge_zero,
  output logic                                     wr_gauge_zero,
  output dma_stats_pkg::dma_stat_t                 stats
);

  import dma_stats_pkg::*;

  localparam logic [`DMA_GAUGE_BITS-1:0] GAUGE_MAX = {`DMA_GAUGE_BITS{1'b1}};

  logic [`DMA_CNT_BITS-1:0]   cnt [DMA_NUM_EVENTS]; // indexed by dma_event_e.
  logic [`DMA_GAUGE_BITS-1:0] rd_gauge;
  logic [`DMA_GAUGE_BITS-1:0] wr_gauge;
  logic [`DMA_GAUGE_BITS-1:0] rd_gauge_nxt;
  logic [`DMA_GAUGE_BITS-1:0] wr_gauge_nxt;
  logic                       rd_err_flag;
  logic                       wr_err_flag;
  logic                       rd_sat_req;           // read request hitting a full gauge.
  logic                       wr_sat_req;
  logic                       clear_q;              // clear aligned with the captured events.
  dma_stat_t                  slice [`DMA_STATS_DELAY];

  // one step of a gauge. up and down together leave it unchanged.
  function automatic logic [`DMA_GAUGE_BITS-1:0] gauge_step(
    input logic [`DMA_GAUGE_BITS-1:0] g,
    input logic                       up,
    input logic                       down
  );
    if (up && !down && g != GAUGE_MAX) begin
      return g + 1'b1;
    end else if (down && !up && g != '0) begin
      return g - 1'b1;
    end
    return g; // saturated, idle, or balanced.
  endfunction

  always_comb begin
    rd_gauge_nxt = clear_q ? '0 : gauge_step(rd_gauge, ev[EV_RD_REQ], ev[EV_RD_DONE]);
    wr_gauge_nxt = clear_q ? '0 : gauge_step(wr_gauge, ev[EV_WR_REQ], ev[EV_WR_DONE]);
  end

  // capture judges completions against the gauge after this edge.
  assign rd_gauge_zero = (rd_gauge_nxt == '0);
  assign wr_gauge_zero = (wr_gauge_nxt == '0);

  assign rd_sat_req = ev[EV_RD_REQ] & ~ev[EV_RD_DONE] & (rd_gauge == GAUGE_MAX);
  assign wr_sat_req = ev[EV_WR_REQ] & ~ev[EV_WR_DONE] & (wr_gauge == GAUGE_MAX);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      for (int i = 0; i < DMA_NUM_EVENTS; i++) begin
        cnt[i] <= '0;
      end
      rd_gauge    <= '0;
      wr_gauge    <= '0;
      rd_err_flag <= 1'b0;
      wr_err_flag <= 1'b0;
      clear_q     <= 1'b0;
    end else begin
      clear_q  <= clear;        // delayed so it meets the strobes sampled with it.
      rd_gauge <= rd_gauge_nxt; // clear is already folded into the next value.
      wr_gauge <= wr_gauge_nxt;
      if (clear_q) begin
        for (int i = 0; i < DMA_NUM_EVENTS; i++) begin
          cnt[i] <= '0;
        end
        rd_err_flag <= 1'b0;
        wr_err_flag <= 1'b0;
      end else begin
        for (int i = 0; i < DMA_NUM_EVENTS; i++) begin
          if (ev[i]) begin
            cnt[i] <= cnt[i] + 1'b1; // wraps at the counter width.
          end
        end
        rd_err_flag <= rd_err_flag | rd_underflow | rd_sat_req;
        wr_err_flag <= wr_err_flag | wr_underflow | wr_sat_req;
      end
    end
  end

  // stage zero of the slice is the live state, later stages are plain flops.
  always_comb begin
    slice[0].rd_req         = cnt[EV_RD_REQ];
    slice[0].wr_req         = cnt[EV_WR_REQ];
    slice[0].rd_done        = cnt[EV_RD_DONE];
    slice[0].wr_done        = cnt[EV_WR_DONE];
    slice[0].axis_rd        = cnt[EV_AXIS_RD];
    slice[0].axis_wr        = cnt[EV_AXIS_WR];
    slice[0].rd_outstanding = rd_gauge;
    slice[0].wr_outstanding = wr_gauge;
    slice[0].rd_err         = rd_err_flag;
    slice[0].wr_err         = wr_err_flag;
  end

  for (genvar s = 1; s < `DMA_STATS_DELAY; s++) begin : g_slice
    always_ff @(posedge aclk) begin
      slice[s] <= slice[s-1];
    end
  end

  assign stats = slice[`DMA_STATS_DELAY-1];

  // capture must never hand over a completion for an empty gauge.
  a_rd_gauge_no_wrap : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (ev[EV_RD_DONE] && !ev[EV_RD_REQ] && !clear_q) |-> (rd_gauge != '0)
  );

  a_wr_gauge_no_wrap : assert property (
    @(posedge aclk) disable iff (!aresetn)
    (ev[EV_WR_DONE] && !ev[EV_WR_REQ] && !clear_q) |-> (wr_gauge != '0)
  );

endmodule

//--- rtl/dma_stats_readout.sv
`timescale 1ns/1ps

`include "dma_stats_config.svh"

module dma_stats_readout (
  input  logic                          aclk,
  input  logic                          aresetn,

  input  dma_stats_pkg::dma_stat_t      stats,   // record from the counting stage.

  input  logic                          rd_en,   // one read per cycle it is high.
  input  dma_reg_pkg::dma_reg_addr_e    rd_addr,
  output logic [`DMA_CNT_BITS-1:0]      rd_data,
  output logic                          rd_valid,
  output logic                          rd_err   // unmapped address.
);

  import dma_reg_pkg::*;

  logic [`DMA_CNT_BITS-1:0] sel_data;
  logic                     sel_err;

  // combinational decode of the register map.
  always_comb begin
    sel_data = '0;
    sel_err  = 1'b0;
    case (rd_addr)
      REG_RD_REQ:  sel_data = stats.rd_req;
      REG_WR_REQ:  sel_data = stats.wr_req;
      REG_RD_DONE: sel_data = stats.rd_done;
      REG_WR_DONE: sel_data = stats.wr_done;
      REG_AXIS_RD: sel_data = stats.axis_rd;
      REG_AXIS_WR: sel_data = stats.axis_wr;
      REG_GAUGES: begin
        sel_data[REG_GAUGE_RD_LSB +: `DMA_GAUGE_BITS] = stats.rd_outstanding;
        sel_data[REG_GAUGE_WR_LSB +: `DMA_GAUGE_BITS] = stats.wr_outstanding;
      end
      REG_ERRORS: begin
        sel_data[REG_ERR_RD_BIT] = stats.rd_err;
        sel_data[REG_ERR_WR_BIT] = stats.wr_err;
      end
      default: sel_err = 1'b1; // data stays zero.
    endcase
  end

  // the valid and error strobes follow each read by one cycle.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_valid <= 1'b0;
      rd_err   <= 1'b0;
    end else begin
      rd_valid <= rd_en;           // exactly one pulse per read.
      rd_err   <= rd_en & sel_err;
    end
  end

  // the data word only changes when a read is taken.
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= sel_data;
    end
  end

endmodule

//--- rtl/dma_stats_top.sv
`timescale 1ns/1ps

`include "dma_stats_config.svh"

module dma_stats_top (
  input  logic                       aclk,
  input  logic                       aresetn,

  // raw event strobes from the DMA engine, one count per high cycle.
  input  logic                       dma_rd_req,
  input  logic                       dma_rd_done,
  input  logic                       dma_wr_req,
  input  logic                       dma_wr_done,
  input  logic                       axis_rd,
  input  logic                       axis_wr,

  input  logic                       clear,

  // host register port.
  input  logic                       rd_en,
  input  dma_reg_pkg::dma_reg_addr_e rd_addr,
  output logic [`DMA_CNT_BITS-1:0]   rd_data,
  output logic                       rd_valid,
  output logic                       rd_err
);

  import dma_stats_pkg::*;

  logic [DMA_NUM_EVENTS-1:0] ev;
  logic                      rd_underflow;
  logic                      wr_underflow;
  logic                      rd_gauge_zero; // fed back from counting to capture.
  logic                      wr_gauge_zero;
  dma_stat_t                 stats;

  // stage 1.
  dma_event_capture i_capture (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .dma_rd_req    (dma_rd_req),
    .dma_rd_done   (dma_rd_done),
    .dma_wr_req    (dma_wr_req),
    .dma_wr_done   (dma_wr_done),
    .axis_rd       (axis_rd),
    .axis_wr       (axis_wr),
    .rd_gauge_zero (rd_gauge_zero),
    .wr_gauge_zero (wr_gauge_zero),
    .ev            (ev),
    .rd_underflow  (rd_underflow),
    .wr_underflow  (wr_underflow)
  );

  // stage 2, counters and the delay slice.
  dma_stats i_stats (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .clear         (clear),
    .ev            (ev),
    .rd_underflow  (rd_underflow),
    .wr_underflow  (wr_underflow),
    .rd_gauge_zero (rd_gauge_zero),
    .wr_gauge_zero (wr_gauge_zero),
    .stats         (stats)
  );

  // stage 3.
  dma_stats_readout i_readout (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .stats    (stats),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rd_err   (rd_err)
  );

endmodule

//--- verif/dma_stats_tb.sv
`timescale 1ns/1ps

`include "dma_stats_config.svh"

module dma_stats_tb;

  import dma_reg_pkg::*;

  localparam int MAX_TESTS    = 32;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_REGS     = 8;  // mapped registers, one unmapped read follows them.
  localparam int MAX_GAP      = `DMA_STATS_DELAY + 9;

  logic                     aclk;
  logic                     aresetn;
  logic                     dma_rd_req;
  logic                     dma_rd_done;
  logic                     dma_wr_req;
  logic                     dma_wr_done;
  logic                     axis_rd;
  logic                     axis_wr;
  logic                     clear;
  logic                     rd_en;
  dma_reg_addr_e            rd_addr;
  logic [`DMA_CNT_BITS-1:0] rd_data;
  logic                     rd_valid;
  logic                     rd_err;

  // one row per golden line. pulse columns follow the counter register order.
  logic [8*32-1:0]          t_name [MAX_TESTS];
  int                       t_clr  [MAX_TESTS];          // 0 none, 1 before, 2 with first strobes.
  int                       t_cnt  [MAX_TESTS][6];
  logic [`DMA_CNT_BITS-1:0] t_exp  [MAX_TESTS][NUM_REGS];

  int          num_tests   = 0;
  int          max_pulse   = 0;
  int          cycle_limit = 0; // zero until the golden file has been read.
  int          cycles      = 0;
  int          valid_seen  = 0;
  int          reads_sent  = 0;
  int          errors      = 0;
  int          bad_tests   = 0;
  logic [31:0] lcg_state;

  dma_stats_top i_dut (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .dma_rd_req  (dma_rd_req),
    .dma_rd_done (dma_rd_done),
    .dma_wr_req  (dma_wr_req),
    .dma_wr_done (dma_wr_done),
    .axis_rd     (axis_rd),
    .axis_wr     (axis_wr),
    .clear       (clear),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .rd_err      (rd_err)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // the run may never outlast its own worst-case length.
  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("test failed");
      $finish;
    end
  end

  always @(negedge aclk) begin
    if (rd_valid === 1'b1) begin
      valid_seen <= valid_seen + 1; // a pulse is one cycle wide, so it counts once.
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // packed text from the file carries leading null bytes.
  function automatic string name_text(input logic [8*32-1:0] raw);
    string s;
    s = "";
    for (int i = 31; i >= 0; i--) begin
      if (raw[i*8 +: 8] != 8'h00) begin
        s = $sformatf("%s%c", s, raw[i*8 +: 8]);
      end
    end
    return s;
  endfunction

  // completions (columns 2 and 3) trail their requests by one cycle.
  function automatic int first_cycle(input int e);
    return (e == 2 || e == 3) ? 1 : 0;
  endfunction

  function automatic int pulse_cycles(input int idx);
    int n;
    n = 0;
    for (int e = 0; e < 6; e++) begin
      if (t_cnt[idx][e] > 0 && first_cycle(e) + t_cnt[idx][e] > n) begin
        n = first_cycle(e) + t_cnt[idx][e];
      end
    end
    return n;
  endfunction

  function automatic logic strobe_on(input int idx, input int e, input int k);
    return (k >= first_cycle(e)) && (k < first_cycle(e) + t_cnt[idx][e]);
  endfunction

  task automatic load_golden();
    int              fd;
    int              code;
    logic [8*32-1:0] tok;
    logic [8*256-1:0] rest;
    string           text;
    fd = $fopen("verif/dma_stats_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/dma_stats_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        code = $fscanf(fd, "%s", tok);
        text = name_text(tok);
        if (code != 1) begin
          text = ""; // end of file reached.
        end else if (text.getc(0) == 8'h23) begin
          code = $fgets(rest, fd); // a leading hash marks a comment line.
        end else begin
          t_name[num_tests] = tok;
          code = $fscanf(fd, "%d %d %d %d %d %d %d", t_clr[num_tests],
                         t_cnt[num_tests][0], t_cnt[num_tests][1], t_cnt[num_tests][2],
                         t_cnt[num_tests][3], t_cnt[num_tests][4], t_cnt[num_tests][5]);
          code += $fscanf(fd, "%h %h %h %h %h %h %h %h",
                          t_exp[num_tests][0], t_exp[num_tests][1], t_exp[num_tests][2],
                          t_exp[num_tests][3], t_exp[num_tests][4], t_exp[num_tests][5],
                          t_exp[num_tests][6], t_exp[num_tests][7]);
          assert (code == 15) else begin
            $display("golden line for %s is incomplete", text);
            errors++;
          end
          if (pulse_cycles(num_tests) > max_pulse) begin
            max_pulse = pulse_cycles(num_tests);
          end
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_pulses(input int idx);
    int n;
    n = pulse_cycles(idx);
    if (t_clr[idx] == 1) begin
      @(negedge aclk);
      clear = 1'b1;
      @(negedge aclk);
      clear = 1'b0;
      @(negedge aclk); // one idle cycle so the clear has landed before any strobe.
    end
    for (int k = 0; k < n; k++) begin
      @(negedge aclk);
      clear       = (t_clr[idx] == 2) && (k == 0); // collides with the first strobes.
      dma_rd_req  = strobe_on(idx, 0, k);
      dma_wr_req  = strobe_on(idx, 1, k);
      dma_rd_done = strobe_on(idx, 2, k);
      dma_wr_done = strobe_on(idx, 3, k);
      axis_rd     = strobe_on(idx, 4, k);
      axis_wr     = strobe_on(idx, 5, k);
    end
    @(negedge aclk);
    clear       = 1'b0;
    dma_rd_req  = 1'b0;
    dma_wr_req  = 1'b0;
    dma_rd_done = 1'b0;
    dma_wr_done = 1'b0;
    axis_rd     = 1'b0;
    axis_wr     = 1'b0;
  endtask

  // back to back reads. each answer is checked on the next falling edge.
  task automatic read_and_check(input int idx, input logic [3:0] unmapped);
    int                       bad;
    string                    name;
    logic [`DMA_CNT_BITS-1:0] exp_data;
    logic                     exp_err;
    bad  = 0;
    name = name_text(t_name[idx]);
    for (int r = 0; r <= NUM_REGS + 1; r++) begin
      @(negedge aclk);
      if (r > 0) begin
        exp_data = '0;             // the unmapped address reads zero.
        exp_err  = (r > NUM_REGS);
        if (r <= NUM_REGS) begin
          exp_data = t_exp[idx][r-1];
        end
        assert (rd_valid === 1'b1) else begin
          $display("%s read %0d got no rd_valid pulse", name, r - 1);
          bad++;
        end
        assert (rd_data === exp_data) else begin
          $display("FAIL %s reg %0d: expected %h, actual %h", name, r - 1, exp_data, rd_data);
          bad++;
        end
        assert (rd_err === exp_err) else begin
          $display("FAIL %s rd_err at read %0d: expected %b, actual %b",
                   name, r - 1, exp_err, rd_err);
          bad++;
        end
      end
      rd_en   = (r <= NUM_REGS);
      rd_addr = (r < NUM_REGS) ? dma_reg_addr_e'(4'(r)) : dma_reg_addr_e'(unmapped);
    end
    reads_sent += NUM_REGS + 1;
    errors     += bad;
    if (bad == 0) begin
      $display("%-14s ok", name);
    end else begin
      bad_tests++;
      $display("%-14s %0d errors", name, bad);
    end
  endtask

  initial begin
    int         gap;
    logic [3:0] unmapped;
    aresetn     = 1'b0;
    dma_rd_req  = 1'b0;
    dma_rd_done = 1'b0;
    dma_wr_req  = 1'b0;
    dma_wr_done = 1'b0;
    axis_rd     = 1'b0;
    axis_wr     = 1'b0;
    clear       = 1'b0;
    rd_en       = 1'b0;
    rd_addr     = REG_RD_REQ;
    lcg_state   = 32'd38895;
    load_golden();
    // the closing checks get the same margin as one test.
    cycle_limit = RESET_CYCLES + 20 + num_tests * (max_pulse + MAX_GAP + 20);
    repeat (RESET_CYCLES) @(negedge aclk);
    aresetn = 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      drive_pulses(t);
      lcg_state = lcg_next(lcg_state);
      gap       = `DMA_STATS_DELAY + 2 + int'(lcg_state[18:16]); // settle before reading.
      lcg_state = lcg_next(lcg_state);
      unmapped  = {1'b1, lcg_state[18:16]};                        // one of addresses 8 to 15.
      repeat (gap) @(negedge aclk);
      read_and_check(t, unmapped);
    end
    @(negedge aclk);
    assert (num_tests > 0) else begin
      $display("the golden file holds no tests");
      errors++;
    end
    assert (valid_seen == reads_sent) else begin
      $display("rd_valid pulsed %0d times for %0d reads", valid_seen, reads_sent);
      errors++;
    end
    $display("summary: %0d tests, %0d with errors, %0d check errors",
             num_tests, bad_tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verif/dma_stats_golden.txt
# name clear(0 none, 1 before, 2 with first strobes) pulses: rd_req wr_req rd_done wr_done axis_rd axis_wr
# then hex registers 0..7: six counters, gauges (wr << 8 | rd), errors (wr << 1 | rd)
reset_zero    0   0   0  0  0  0  0    0   0 0 0  0  0  0000 0
rd_basic      0   5   0  3  0  0  0    5   0 3 0  0  0  0002 0
all_strobes   0   4   6  4  2 10  7    9   6 7 2  a  7  0402 0
rd_orphan     0   0   0  5  0  0  0    9   6 9 2  a  7  0400 1
clear_all     1   0   0  0  0  0  0    0   0 0 0  0  0  0000 0
wr_orphan     0   0   0  0  3  0  4    0   0 0 0  0  4  0000 2
clear_wins    2   3   2  0  0  5  1    2   1 0 0  4  0  0102 0
wr_saturate   0   0 300  0  0  0  0    2 12d 0 0  4  0  ff02 2
wr_drain      0   0   0  0 10  0  0    2 12d 0 a  4  0  f502 2
rd_fill       1 255   0  0  0  0  0   ff   0 0 0  0  0  00ff 0
rd_over       0   1   0  0  0  0  0  100   0 0 0  0  0  00ff 1
rd_balance    0   3   0  3  0  0  0  103   0 3 0  0  0  00fe 1
axis_only     1   0   0  0  0 17 33    0   0 0 0 11 21  0000 0
mixed_orphan  0   2   1  2  3 18 35    2   1 2 1 23 44  0000 2

//--- flist.f
+incdir+rtl
rtl/dma_stats_pkg.sv
rtl/dma_reg_pkg.sv
rtl/dma_event_capture.sv
rtl/dma_stats.sv
rtl/dma_stats_readout.sv
rtl/dma_stats_top.sv
verif/dma_stats_tb.sv

//--- Makefile
TOP = dma_stats_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
